/* all.f */
logic/pmp_pkg.sv
logic/pmp_region_match.sv
logic/pmp_access_check.sv
logic/pmp_csr_file.sv
logic/pmp_unit.sv
dv/pmp_tb.sv

/* dv/pmp_tb.sv */
/* Testbench for pmp_unit with 16 entries. A reference model of the CSRs and the check
   rule runs beside the DUT, and concurrent assertions compare the two every cycle */
`timescale 1ns/1ps
`default_nettype none

module pmp_tb
  import pmp_pkg::*;
();

  localparam int ACK_LIMIT = 8;

  logic        CLK;
  logic        nRST;
  logic [11:0] i_csr_addr;
  logic        i_csr_we;
  logic [31:0] i_csr_wdata;
  logic [31:0] o_csr_rdata;
  logic        o_csr_ack;
  pmp_access_t i_dacc;
  pmp_access_t i_iacc;
  priv_level_t i_priv;
  logic        i_mprv;
  priv_level_t i_mpp;
  pmp_fault_t  o_fault;

  // Reference model state
  logic [7:0]  m_cfg  [16];
  logic [31:0] m_addr [16];
  logic [31:0] exp_rdata;
  logic        exp_ack;
  logic [2:0]  exp_fault;
  logic [2:0]  d_exp;
  logic [2:0]  i_exp;
  logic        d_en;
  logic        f_en;

  integer      seed;
  int          err_count;
  int          n_tests;
  int          test_start_errs;
  string       test_name;
  logic        timed_out;
  logic [11:0] timeout_addr;

  pmp_unit #(
    .N_ENTRIES (16)
  ) u_pmp_unit (
    .CLK         (CLK),
    .nRST        (nRST),
    .i_csr_addr  (i_csr_addr),
    .i_csr_we    (i_csr_we),
    .i_csr_wdata (i_csr_wdata),
    .o_csr_rdata (o_csr_rdata),
    .o_csr_ack   (o_csr_ack),
    .i_dacc      (i_dacc),
    .i_iacc      (i_iacc),
    .i_priv      (i_priv),
    .i_mprv      (i_mprv),
    .i_mpp       (i_mpp),
    .o_fault     (o_fault)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // CSR write rules, applied on the same edge as the DUT
  always @(posedge CLK or negedge nRST) begin : model_update
    logic [7:0] b;
    logic       frozen;
    int         e;
    if (!nRST) begin
      for (int k = 0; k < 16; k++) begin
        m_cfg[k]  <= '0;
        m_addr[k] <= '0;
      end
    end else if (i_csr_we) begin
      if (i_csr_addr[11:2] == 10'b0011_1010_00) begin  // pmpcfg0..3
        for (int k = 0; k < 4; k++) begin
          e = int'(i_csr_addr[1:0]) * 4 + k;
          b = i_csr_wdata[8*k +: 8];
          b[6:5] = 2'b00;
          if (!b[0]) b[1] = 1'b0;
          if (!m_cfg[e][7]) m_cfg[e] <= b;
        end
      end
      if (i_csr_addr[11:4] == 8'h3B) begin
        e = int'(i_csr_addr[3:0]);
        frozen = m_cfg[e][7];
        if (e < 15) frozen = frozen | (m_cfg[e+1][7] && (m_cfg[e+1][4:3] == 2'b01));
        if (!frozen) m_addr[e] <= i_csr_wdata;
      end
    end
  end

  // Returns {ack, data} for a CSR read
  function automatic logic [32:0] model_csr(input logic [11:0] a);
    logic [32:0] res;
    int          base;
    res = '0;
    if (a[11:2] == 10'b0011_1010_00) begin
      base = int'(a[1:0]) * 4;
      res = {1'b1, m_cfg[base+3], m_cfg[base+2], m_cfg[base+1], m_cfg[base]};
    end else if (a[11:4] == 8'h3B) begin
      res = {1'b1, m_addr[a[3:0]]};
    end
    return res;
  endfunction

  // Returns {load, store, inst} for one access
  function automatic logic [2:0] model_check(input logic [31:0] byte_addr, input logic r,
                                             input logic w, input logic x, input logic enf);
    logic [31:0] word;
    logic [31:0] pa;
    logic [31:0] lo;
    logic [7:0]  c;
    logic        found;
    logic        hit;
    logic        deny;
    logic        fail;
    int          n;
    word  = {2'b00, byte_addr[31:2]};
    lo    = '0;
    c     = '0;
    found = 1'b0;
    for (int e = 0; e < 16; e++) begin
      pa = {2'b00, m_addr[e][29:0]};
      n  = 0;
      for (int b = 0; b < 30; b++) begin
        if (pa[b] && (n == b)) n = b + 1;  // Count trailing ones
      end
      case (m_cfg[e][4:3])
        2'b01:   hit = (word >= lo) && (word < pa);
        2'b10:   hit = (word == pa);
        2'b11:   hit = ((word >> (n + 1)) == (pa >> (n + 1)));
        default: hit = 1'b0;
      endcase
      if (hit && !found) begin
        found = 1'b1;
        c     = m_cfg[e];
      end
      lo = pa;
    end
    deny = (r & ~c[0]) | (w & ~c[1]) | (x & ~c[2]);
    fail = (enf | (found & c[7])) & (~found | deny);
    return {fail & r, fail & w, fail & x};
  endfunction

  always_comb begin
    {exp_ack, exp_rdata} = model_csr(i_csr_addr);
    d_en  = (i_priv != M_MODE) || (i_mprv && (i_mpp != M_MODE));
    f_en  = (i_priv != M_MODE);
    d_exp = model_check(i_dacc.addr, i_dacc.r, i_dacc.w, 1'b0, d_en);
    i_exp = model_check(i_iacc.addr, 1'b0, 1'b0, i_iacc.x, f_en);
    exp_fault = {d_exp[2], d_exp[1], i_exp[0] & ~(d_exp[2] | d_exp[1])};
  end

  a_rdata: assert property (@(posedge CLK) disable iff (!nRST) o_csr_rdata == exp_rdata)
    else begin
      $display("FAIL %0t: CSR 0x%03h read 0x%08h, expected 0x%08h", $time,
               $sampled(i_csr_addr), $sampled(o_csr_rdata), $sampled(exp_rdata));
      err_count++;
    end

  a_ack: assert property (@(posedge CLK) disable iff (!nRST) o_csr_ack == exp_ack)
    else begin
      $display("FAIL %0t: CSR 0x%03h ack %0b, expected %0b", $time,
               $sampled(i_csr_addr), $sampled(o_csr_ack), $sampled(exp_ack));
      err_count++;
    end

  a_fault: assert property (@(posedge CLK) disable iff (!nRST) o_fault == exp_fault)
    else begin
      $display("FAIL %0t: fault %03b for data 0x%08h / fetch 0x%08h, expected %03b", $time,
               $sampled(o_fault), $sampled(i_dacc.addr), $sampled(i_iacc.addr),
               $sampled(exp_fault));
      err_count++;
    end

  initial begin
    wait (timed_out);
    $display("Timeout: no CSR ack came back for address 0x%03h", timeout_addr);
    $display("SIMULATION FAILED");
    $finish;
  end

  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic open_test(input string name);
    test_name       = name;
    test_start_errs = err_count;
  endtask

  task automatic close_test();
    n_tests++;
    $display("[test %0d] %s done, errors=%0d", n_tests, test_name,
             err_count - test_start_errs);
  endtask

  task automatic csr_write(input logic [11:0] a, input logic [31:0] d);
    i_csr_addr  = a;
    i_csr_we    = 1'b1;
    i_csr_wdata = d;
    next_cycle();
    i_csr_we    = 1'b0;
    i_csr_wdata = '0;
  endtask

  // Holds a known address until ack shows, then one more edge for the checks
  task automatic csr_read(input logic [11:0] a);
    int waited;
    waited     = 0;
    i_csr_addr = a;
    i_csr_we   = 1'b0;
    #1;
    while (!o_csr_ack && (waited < ACK_LIMIT)) begin
      next_cycle();
      waited++;
    end
    if (!o_csr_ack) begin
      timeout_addr = a;
      timed_out    = 1'b1;
    end
    next_cycle();
  endtask

  task automatic csr_unknown(input logic [11:0] a);
    i_csr_addr = a;
    next_cycle();
  endtask

  task automatic drive_access(input priv_level_t p, input logic mprv, input priv_level_t mpp,
                              input logic [31:0] da, input logic r, input logic w,
                              input logic [31:0] ia, input logic x);
    i_priv      = p;
    i_mprv      = mprv;
    i_mpp       = mpp;
    i_dacc.addr = da;
    i_dacc.r    = r;
    i_dacc.w    = w;
    i_dacc.x    = x;  // Ignored on the data port
    i_iacc.addr = ia;
    i_iacc.r    = r;  // Only x counts on the fetch port
    i_iacc.w    = w;
    i_iacc.x    = x;
    next_cycle();
  endtask

  // Load, store and fetch at one address, one per cycle
  task automatic probe(input logic [31:0] a, input priv_level_t p);
    drive_access(p, 1'b0, U_MODE, a, 1'b1, 1'b0, a, 1'b0);
    drive_access(p, 1'b0, U_MODE, a, 1'b0, 1'b1, a, 1'b0);
    drive_access(p, 1'b0, U_MODE, a, 1'b0, 1'b0, a, 1'b1);
  endtask

  task automatic random_accesses(input int count, input logic [31:0] mask);
    logic [31:0] rv;
    priv_level_t p;
    priv_level_t mp;
    for (int k = 0; k < count; k++) begin
      rv = $random(seed);
      case (rv[1:0])
        2'b00:   p = U_MODE;
        2'b01:   p = S_MODE;
        default: p = M_MODE;
      endcase
      mp = rv[3] ? M_MODE : (rv[2] ? S_MODE : U_MODE);
      drive_access(p, rv[4], mp, $random(seed) & mask, rv[5], rv[6],
                   $random(seed) & mask, rv[7]);
    end
    drive_access(U_MODE, 1'b0, U_MODE, '0, 1'b0, 1'b0, '0, 1'b0);
  endtask

  task automatic reset_values();
    open_test("reset values");
    for (int k = 0; k < 4; k++) csr_read(PMPCFG_BASE + 12'(k));
    for (int k = 0; k < 16; k++) csr_read(PMPADDR_BASE + 12'(k));
    csr_unknown(12'h3A4);
    csr_unknown(12'h3AF);
    csr_unknown(12'h300);
    csr_unknown(12'h3C0);
    probe(32'h0000_0000, U_MODE);  // Nothing matches, all fault
    probe(32'h8000_0000, S_MODE);
    probe(32'h0000_1234, M_MODE);
    random_accesses(10, 32'hFFFF_FFFC);
    close_test();
  endtask

  task automatic warl_fields();
    open_test("WARL fields");
    csr_write(12'h3A0, 32'h627F_6E22);  // Reserved bits and W without R
    csr_read(12'h3A0);
    csr_write(12'h3A1, 32'h657B_6A63);
    csr_read(12'h3A1);
    csr_write(12'h3A0, 32'h0);
    csr_write(12'h3A1, 32'h0);
    csr_read(12'h3A0);
    csr_read(12'h3A1);
    close_test();
  endtask

  task automatic region_perms();
    logic [31:0] pts [16];
    open_test("region permissions");
    pts = '{32'h0, 32'hFFC, 32'h1000, 32'h1FFC, 32'h2000, 32'h2003, 32'h2004, 32'h3FFC,
            32'h4000, 32'h40FC, 32'h4100, 32'h5FFC, 32'h6000, 32'h6FFC, 32'h7000, 32'h7FFC};
    csr_write(12'h3B0, 32'h0000_0400);  // TOR [0, 0x1000) from entry 0
    csr_write(12'h3B1, 32'h0000_0800);  // NA4 at 0x2000
    csr_write(12'h3B2, 32'h0000_101F);  // NAPOT 256 bytes at 0x4000
    csr_write(12'h3B3, 32'h0000_1800);
    csr_write(12'h3B4, 32'h0000_1C00);  // TOR [0x6000, 0x7000)
    csr_write(12'h3A0, 32'h001C_1309);
    csr_write(12'h3A1, 32'h0000_000D);
    csr_read(12'h3A0);
    csr_read(12'h3A1);
    for (int k = 0; k < 16; k++) probe(pts[k], U_MODE);
    probe(32'h0000_4080, S_MODE);
    random_accesses(16, 32'h0000_7FFC);
    close_test();
  endtask

  task automatic overlap_priority();
    open_test("overlap priority");
    csr_write(12'h3B5, 32'h0000_1FFF);  // NAPOT RWX over the first 64 KiB
    csr_write(12'h3A1, 32'h0000_1F0D);
    csr_read(12'h3A1);
    probe(32'h0000_0100, U_MODE);
    probe(32'h0000_2000, U_MODE);
    probe(32'h0000_3000, U_MODE);
    probe(32'h0000_4000, U_MODE);
    probe(32'h0000_6800, U_MODE);
    probe(32'h0000_FFFC, U_MODE);
    probe(32'h0001_0000, U_MODE);
    close_test();
  endtask

  task automatic lock_rules();
    open_test("lock rules");
    csr_write(12'h3B8, 32'h0000_4000);
    csr_write(12'h3B9, 32'h0000_4400);
    csr_write(12'h3A2, 32'h0000_8900);  // Entry 9 locked TOR, read only
    csr_read(12'h3A2);
    csr_write(12'h3B8, 32'h0000_5000);  // Frozen by the locked TOR above
    csr_write(12'h3B9, 32'h0000_5000);
    csr_read(12'h3B8);
    csr_read(12'h3B9);
    csr_write(12'h3A2, 32'h0000_1F1F);  // Only entry 8 may change
    csr_read(12'h3A2);
    csr_write(12'h3BA, 32'h0000_6000);
    csr_read(12'h3BA);
    probe(32'h0001_0800, M_MODE);
    probe(32'h0001_0000, M_MODE);
    probe(32'h0001_1000, M_MODE);
    probe(32'h0002_0000, M_MODE);
    probe(32'h0001_0800, U_MODE);
    close_test();
  endtask

  task automatic priv_rules();
    open_test("privilege rules");
    drive_access(M_MODE, 1'b1, U_MODE, 32'h0003_0000, 1'b1, 1'b0, 32'h0003_0000, 1'b1);
    drive_access(M_MODE, 1'b1, U_MODE, 32'h0003_0000, 1'b0, 1'b1, 32'h0003_0000, 1'b1);
    drive_access(M_MODE, 1'b1, S_MODE, 32'h0003_0000, 1'b1, 1'b1, 32'h0003_0000, 1'b1);
    drive_access(M_MODE, 1'b1, M_MODE, 32'h0003_0000, 1'b1, 1'b1, 32'h0003_0000, 1'b1);
    drive_access(M_MODE, 1'b0, U_MODE, 32'h0003_0000, 1'b1, 1'b1, 32'h0003_0000, 1'b1);
    // Data and fetch both fault, data wins
    drive_access(S_MODE, 1'b0, M_MODE, 32'h0003_0000, 1'b1, 1'b0, 32'h0003_0000, 1'b1);
    drive_access(U_MODE, 1'b0, U_MODE, 32'h0000_0100, 1'b1, 1'b0, 32'h0003_0000, 1'b1);
    random_accesses(40, 32'h0001_FFFC);
    close_test();
  endtask

  initial begin
    seed         = 69578;
    err_count    = 0;
    n_tests      = 0;
    timed_out    = 1'b0;
    timeout_addr = '0;
    nRST         = 1'b0;
    i_csr_addr   = '0;
    i_csr_we     = 1'b0;
    i_csr_wdata  = '0;
    i_dacc       = '0;
    i_iacc       = '0;
    i_priv       = U_MODE;
    i_mprv       = 1'b0;
    i_mpp        = U_MODE;
    repeat (10) @(posedge CLK);
    #1;
    nRST = 1'b1;
    next_cycle();

    reset_values();
    warl_fields();
    region_perms();
    overlap_priority();
    lock_rules();
    priv_rules();
    next_cycle();

    $display("Tests run: %0d, errors: %0d", n_tests, err_count);
    if (err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/pmp_access_check.sv */
/* Checks one access port against all entries, lowest index wins.
   Any request bit the caller does not mask off takes part in the permission test */
`timescale 1ns/1ps
`default_nettype none

module pmp_access_check
  import pmp_pkg::*;
#(
  parameter int N_ENTRIES = 16
) (
  input  wire pmp_access_t                 i_acc,
  input  wire logic                        i_enforce,
  input  wire pmp_cfg_t  [N_ENTRIES-1:0]   i_cfg,
  input  wire pmp_addr_t [N_ENTRIES-1:0]   i_addr,
  output pmp_fault_t                       o_fault
);

  pmp_addr_t [N_ENTRIES-1:0] prev_addr;
  logic      [N_ENTRIES-1:0] hit;
  pmp_cfg_t                  sel_cfg;
  logic                      found;
  logic                      deny;
  logic                      check_on;
  logic                      fail;

  // TOR lower bound is the previous entry, entry 0 gets zero
  assign prev_addr = i_addr << $bits(pmp_addr_t);

  for (genvar e = 0; e < N_ENTRIES; e++) begin : g_match
    pmp_region_match u_match (
      .i_word_addr (i_acc.addr[31:2]),
      .i_cfg       (i_cfg[e]),
      .i_addr      (i_addr[e]),
      .i_prev_addr (prev_addr[e]),
      .o_match     (hit[e])
    );
  end

  // Walk downward so the lowest matching index is left standing
  always_comb begin
    sel_cfg = '0;
    found   = 1'b0;
    for (int e = N_ENTRIES - 1; e >= 0; e--) begin
      if (hit[e]) begin
        sel_cfg = i_cfg[e];
        found   = 1'b1;
      end
    end
  end

  assign deny = (i_acc.r & ~sel_cfg.R) |
                (i_acc.w & ~sel_cfg.W) |
                (i_acc.x & ~sel_cfg.X);

  // Without enforcement only a locked match is checked
  assign check_on = i_enforce | (found & sel_cfg.L);
  assign fail     = check_on & (~found | deny);  // No match faults only when enforced

  assign o_fault.load  = fail & i_acc.r;
  assign o_fault.store = fail & i_acc.w;
  assign o_fault.inst  = fail & i_acc.x;

  // A fault needs its request, and needs enforcement or a locked match
  always_comb begin
    a_fault_qualified: assert final (
      ((o_fault & ~{i_acc.r, i_acc.w, i_acc.x}) == '0) &&
      (i_enforce || (found && sel_cfg.L) || (o_fault == '0))
    ) else $error("PMP fault raised without request or enforcement");
  end

endmodule

`default_nettype wire

/* logic/pmp_csr_file.sv */
/* pmpcfg/pmpaddr storage, N_ENTRIES must be a multiple of 4 and at most 16.
   Writes land on the next CLK edge, read data and ack are combinational */
`timescale 1ns/1ps
`default_nettype none

module pmp_csr_file
  import pmp_pkg::*;
#(
  parameter int N_ENTRIES = 16
) (
  input  wire logic                     CLK,
  input  wire logic                     nRST,
  input  wire logic [11:0]              i_csr_addr,
  input  wire logic                     i_csr_we,
  input  wire logic [31:0]              i_csr_wdata,
  output logic [31:0]                   o_csr_rdata,
  output logic                          o_csr_ack,
  output pmp_cfg_t  [N_ENTRIES-1:0]     o_cfg,
  output pmp_addr_t [N_ENTRIES-1:0]     o_addr
);

  localparam int N_CFG = N_ENTRIES / 4;

  pmp_cfg_t  [N_ENTRIES-1:0] cfg_q, cfg_d;
  pmp_addr_t [N_ENTRIES-1:0] addr_q, addr_d;

  logic [3:0]           csr_idx;
  logic                 cfg_hit;
  logic                 addr_hit;
  logic [N_ENTRIES-1:0] tor_locked;
  logic [N_ENTRIES-1:0] addr_frozen;

  pmp_cfg_word_u wr_word;
  pmp_cfg_word_u warl_word;
  pmp_cfg_word_u rd_word;

  assign csr_idx  = i_csr_addr[3:0];
  assign cfg_hit  = (i_csr_addr[11:4] == PMPCFG_BASE[11:4]) &&
                    ({1'b0, csr_idx} < 5'(N_CFG));
  assign addr_hit = (i_csr_addr[11:4] == PMPADDR_BASE[11:4]) &&
                    ({1'b0, csr_idx} < 5'(N_ENTRIES));

  // pmpaddr(i) is frozen by its own lock or by a locked TOR entry i+1
  always_comb begin
    for (int e = 0; e < N_ENTRIES; e++) begin
      tor_locked[e] = cfg_q[e].L && (cfg_q[e].A == TOR);
    end
  end

  always_comb begin
    for (int e = 0; e < N_ENTRIES; e++) begin
      addr_frozen[e] = cfg_q[e].L;
    end
    addr_frozen = addr_frozen | (tor_locked >> 1);  // Top entry has no successor
  end

  // WARL cleanup of a written cfg word
  always_comb begin
    wr_word.raw = i_csr_wdata;
    warl_word   = wr_word;
    for (int k = 0; k < 4; k++) begin
      warl_word.entry[k].reserved = '0;
      if (!wr_word.entry[k].R) begin
        warl_word.entry[k].W = 1'b0;  // W without R is reserved
      end
    end
  end

  always_comb begin
    cfg_d  = cfg_q;
    addr_d = addr_q;
    for (int e = 0; e < N_ENTRIES; e++) begin
      // Locked bytes keep their old value, the rest of the word still lands
      if (i_csr_we && cfg_hit && (csr_idx == 4'(e / 4)) && !cfg_q[e].L) begin
        cfg_d[e] = warl_word.entry[e % 4];
      end
      if (i_csr_we && addr_hit && (csr_idx == 4'(e)) && !addr_frozen[e]) begin
        addr_d[e] = i_csr_wdata;
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cfg_q  <= '0;  // All entries OFF
      addr_q <= '0;
    end else begin
      cfg_q  <= cfg_d;
      addr_q <= addr_d;
    end
  end

  // Read-back
  always_comb begin
    rd_word.raw = '0;
    o_csr_rdata = '0;
    for (int e = 0; e < N_ENTRIES; e++) begin
      if (csr_idx == 4'(e / 4)) begin
        rd_word.entry[e % 4] = cfg_q[e];
      end
    end
    if (cfg_hit) begin
      o_csr_rdata = rd_word.raw;
    end
    for (int e = 0; e < N_ENTRIES; e++) begin
      if (addr_hit && (csr_idx == 4'(e))) begin
        o_csr_rdata = addr_q[e];
      end
    end
  end

  assign o_csr_ack = cfg_hit | addr_hit;
  assign o_cfg     = cfg_q;
  assign o_addr    = addr_q;

  // Once L is set only reset may clear the entry
  for (genvar e = 0; e < N_ENTRIES; e++) begin : g_lock_chk
    a_locked_cfg_stable: assert property (
      @(posedge CLK) disable iff (!nRST)
      cfg_q[e].L |=> $stable(cfg_q[e])
    ) else $error("Locked PMP entry %0d changed its cfg", e);
  end

endmodule

`default_nettype wire

/* logic/pmp_pkg.sv */
/* PMP types for RV32 under privileged spec 1.12, 4-byte granularity and 32-bit physical
   addresses only. Smepmp (MML, MMWP, RLB) is not modelled */
`default_nettype none

package pmp_pkg;

  // Address-matching mode held in the A field
  typedef enum logic [1:0] {
    OFF   = 2'b00,
    TOR   = 2'b01,
    NA4   = 2'b10,
    NAPOT = 2'b11
  } pmp_mode_e;

  // One pmpcfg byte, MSB first
  typedef struct packed {
    logic      L;
    logic [1:0] reserved;
    pmp_mode_e A;
    logic      X;
    logic      W;
    logic      R;
  } pmp_cfg_t;

  // A pmpcfg CSR word, seen as raw bus data or as four entry bytes
  typedef union packed {
    logic [31:0]        raw;
    pmp_cfg_t [3:0]     entry;  // entry[0] sits in bits 7:0
  } pmp_cfg_word_u;

  // pmpaddr holds address bits 33:2, only 29:0 are meaningful here
  typedef logic [31:0] pmp_addr_t;

  // One access request
  typedef struct packed {
    logic [31:0] addr;
    logic        r;
    logic        w;
    logic        x;
  } pmp_access_t;

  typedef struct packed {
    logic load;
    logic store;
    logic inst;
  } pmp_fault_t;

  typedef enum logic [1:0] {
    U_MODE = 2'b00,
    S_MODE = 2'b01,
    M_MODE = 2'b11
  } priv_level_t;

  // CSR base addresses
  localparam logic [11:0] PMPCFG_BASE  = 12'h3A0;
  localparam logic [11:0] PMPADDR_BASE = 12'h3B0;

endpackage

`default_nettype wire

/* logic/pmp_region_match.sv */
/* Region test for one PMP entry on a word address, 4-byte granularity.
   Only pmpaddr bits 29:0 are compared, so 34-bit physical addresses are not covered */
`timescale 1ns/1ps
`default_nettype none

module pmp_region_match
  import pmp_pkg::*;
(
  input  wire logic [29:0] i_word_addr,
  input  wire pmp_cfg_t    i_cfg,
  input  wire pmp_addr_t   i_addr,
  input  wire pmp_addr_t   i_prev_addr,  // Zero for entry 0
  output logic             o_match
);

  logic [29:0] base;
  logic [29:0] prev_base;
  logic [29:0] napot_mask;
  logic        tor_hit;
  logic        na4_hit;
  logic        napot_hit;

  assign base      = i_addr[29:0];
  assign prev_base = i_prev_addr[29:0];

  // Trailing ones plus the next zero bit, so n ones give 2^(n+1) words
  assign napot_mask = base ^ (base + 30'd1);

  assign tor_hit   = (i_word_addr >= prev_base) && (i_word_addr < base);  // Empty if prev >= addr
  assign na4_hit   = (i_word_addr == base);
  assign napot_hit = ((i_word_addr & ~napot_mask) == (base & ~napot_mask));

  always_comb begin
    case (i_cfg.A)
      TOR:     o_match = tor_hit;
      NA4:     o_match = na4_hit;
      NAPOT:   o_match = napot_hit;
      default: o_match = 1'b0;  // OFF
    endcase
  end

endmodule

`default_nettype wire

/* logic/pmp_unit.sv */
/* PMP top level, checks are combinational with no back-pressure.
   A data fault hides a same-cycle fetch fault */
`timescale 1ns/1ps
`default_nettype none

module pmp_unit
  import pmp_pkg::*;
#(
  parameter int N_ENTRIES = 16
) (
  input  wire logic        CLK,
  input  wire logic        nRST,
  input  wire logic [11:0] i_csr_addr,
  input  wire logic        i_csr_we,
  input  wire logic [31:0] i_csr_wdata,
  output logic [31:0]      o_csr_rdata,
  output logic             o_csr_ack,
  input  wire pmp_access_t i_dacc,
  input  wire pmp_access_t i_iacc,
  input  wire priv_level_t i_priv,
  input  wire logic        i_mprv,
  input  wire priv_level_t i_mpp,
  output pmp_fault_t       o_fault
);

  pmp_cfg_t  [N_ENTRIES-1:0] cfg;
  pmp_addr_t [N_ENTRIES-1:0] addr;

  pmp_access_t dacc;
  pmp_access_t iacc;
  logic        d_enforce;
  logic        f_enforce;
  pmp_fault_t  d_fault;
  pmp_fault_t  f_fault;

  pmp_csr_file #(
    .N_ENTRIES (N_ENTRIES)
  ) u_csr_file (
    .CLK         (CLK),
    .nRST        (nRST),
    .i_csr_addr  (i_csr_addr),
    .i_csr_we    (i_csr_we),
    .i_csr_wdata (i_csr_wdata),
    .o_csr_rdata (o_csr_rdata),
    .o_csr_ack   (o_csr_ack),
    .o_cfg       (cfg),
    .o_addr      (addr)
  );

  // Data port never fetches, fetch port only executes
  always_comb begin
    dacc   = i_dacc;
    dacc.x = 1'b0;
    iacc   = i_iacc;
    iacc.r = 1'b0;
    iacc.w = 1'b0;
  end

  // MPRV borrows MPP for loads and stores only
  assign d_enforce = (i_priv != M_MODE) || (i_mprv && (i_mpp != M_MODE));
  assign f_enforce = (i_priv != M_MODE);

  pmp_access_check #(
    .N_ENTRIES (N_ENTRIES)
  ) u_dcheck (
    .i_acc     (dacc),
    .i_enforce (d_enforce),
    .i_cfg     (cfg),
    .i_addr    (addr),
    .o_fault   (d_fault)
  );

  pmp_access_check #(
    .N_ENTRIES (N_ENTRIES)
  ) u_icheck (
    .i_acc     (iacc),
    .i_enforce (f_enforce),
    .i_cfg     (cfg),
    .i_addr    (addr),
    .o_fault   (f_fault)
  );

  assign o_fault.load  = d_fault.load;
  assign o_fault.store = d_fault.store;
  assign o_fault.inst  = f_fault.inst & ~(d_fault.load | d_fault.store);  // Data first

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the PMP testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module pmp_tb -Mdir obj_dir -o pmp_sim

if ! ./obj_dir/pmp_sim > sim.log 2>&1; then
  cat sim.log
  echo "Simulator exited with an error"
  exit 1
fi
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  exit 0
fi
exit 1
